// ==== tomasulo_pkg.sv ====
// ################################################
// shared widths, depths, index and tag types, ALU op codes
// ################################################
package tomasulo_pkg;

    localparam int XLEN       = 32;   // data word
    localparam int NUM_REGS   = 32;   // architectural regs
    localparam int REG_ADDR_W = 5;    // reg index bits
    localparam int ROB_DEPTH  = 8;    // reorder buffer entries
    localparam int ROB_TAG_W  = 3;    // rename tag bits
    localparam int RS_DEPTH   = 4;    // station entries

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [ROB_TAG_W-1:0]  rob_tag_t;   // rob slot, doubles as rename tag

    // RV32I integer ALU operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

endpackage

// ==== reg_rename_file.sv ====
// ################################################
// register file with busy flags and rename tags
// ################################################
`timescale 1ns/10ps

module reg_rename_file
    import tomasulo_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output logic     rf1_busy,
    output logic     rf2_busy,
    output word_t    rf1_value,
    output word_t    rf2_value,
    output rob_tag_t rf1_tag,
    output rob_tag_t rf2_tag,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    input  rob_tag_t alloc_tag,
    input  logic     commit_valid,
    input  reg_idx_t commit_rd,
    input  rob_tag_t commit_tag,
    input  word_t    commit_value
);

    word_t    reg_value [NUM_REGS];   // architectural state
    logic     reg_busy  [NUM_REGS];   // waiting on an in-flight producer
    rob_tag_t reg_tag   [NUM_REGS];   // rob slot of latest producer

    // x0 reads as zero and never waits
    assign rf1_busy  = (rs1 != '0) && reg_busy[rs1];
    assign rf2_busy  = (rs2 != '0) && reg_busy[rs2];
    assign rf1_value = (rs1 == '0) ? '0 : reg_value[rs1];
    assign rf2_value = (rs2 == '0) ? '0 : reg_value[rs2];
    assign rf1_tag   = reg_tag[rs1];
    assign rf2_tag   = reg_tag[rs2];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                reg_value[i] <= '0;
                reg_busy[i]  <= 1'b0;
                reg_tag[i]   <= '0;
            end
        end
        else if (rdy_in)
        begin
            if (commit_valid && (commit_rd != '0))
            begin
                reg_value[commit_rd] <= commit_value;
                if (reg_tag[commit_rd] == commit_tag)   // only the latest producer frees it
                begin
                    reg_busy[commit_rd] <= 1'b0;
                end
            end
            // a rename at the same edge overrides the busy clear above
            if (alloc && (alloc_rd != '0))
            begin
                reg_busy[alloc_rd] <= 1'b1;
                reg_tag[alloc_rd]  <= alloc_tag;
            end
        end
    end

endmodule

// ==== reorder_buffer.sv ====
// ################################################
// reorder buffer: circular in-order commit queue, forwarding lookup
// ################################################
`timescale 1ns/10ps

module reorder_buffer
    import tomasulo_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    output rob_tag_t rob_tail,
    output logic     rob_full,
    input  rob_tag_t lookup1_tag,
    input  rob_tag_t lookup2_tag,
    output logic     fwd1_ready,
    output logic     fwd2_ready,
    output word_t    fwd1_value,
    output word_t    fwd2_value,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output rob_tag_t commit_tag,
    output word_t    commit_value
);

    reg_idx_t           rob_rd    [ROB_DEPTH];   // destination per slot
    logic               rob_ready [ROB_DEPTH];   // result has arrived
    word_t              rob_value [ROB_DEPTH];
    rob_tag_t           head;                    // oldest in flight
    rob_tag_t           tail;                    // next free slot
    logic [ROB_TAG_W:0] count;                   // occupancy, 0..ROB_DEPTH
    logic               retire;
    logic               commit_pending;          // held across a pause

    assign rob_tail = tail;
    assign rob_full = (count == ROB_DEPTH);
    assign retire   = (count != '0) && rob_ready[head];

    // ready flag stays set after retire until the slot is reused,
    // so a register still tagged here in the commit cycle forwards fine
    assign fwd1_ready = rob_ready[lookup1_tag];
    assign fwd2_ready = rob_ready[lookup2_tag];
    assign fwd1_value = rob_value[lookup1_tag];
    assign fwd2_value = rob_value[lookup2_tag];

    assign commit_valid = commit_pending & rdy_in;   // no pulse while paused

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_pending <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++)
            begin
                rob_ready[i] <= 1'b0;
            end
        end
        else if (rdy_in)
        begin
            commit_pending <= retire;   // one-cycle pulse per retired head
            if (alloc)
            begin
                rob_ready[tail] <= 1'b0;
                tail            <= tail + 1'b1;   // wraps at depth
            end
            if (cdb_valid)
            begin
                rob_ready[cdb_tag] <= 1'b1;   // never the slot being allocated
            end
            if (retire)
            begin
                head <= head + 1'b1;
            end
            count <= count + (alloc ? 1'b1 : 1'b0) - (retire ? 1'b1 : 1'b0);
        end
    end

    // payload side, no reset
    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (alloc)
            begin
                rob_rd[tail] <= alloc_rd;
            end
            if (cdb_valid)
            begin
                rob_value[cdb_tag] <= cdb_value;
            end
            if (retire)
            begin
                commit_rd    <= rob_rd[head];
                commit_tag   <= head;
                commit_value <= rob_value[head];
            end
        end
    end

endmodule

// ==== reservation_station.sv ====
// ################################################
// reservation station: operand capture, oldest-ready issue, ALU
// ################################################
`timescale 1ns/10ps

module reservation_station
    import tomasulo_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,
    input  logic     alloc,
    input  alu_op_e  alloc_op,
    input  rob_tag_t alloc_tag,
    input  logic     src1_ready,
    input  logic     src2_ready,
    input  word_t    src1_value,
    input  word_t    src2_value,
    input  rob_tag_t src1_tag,
    input  rob_tag_t src2_tag,
    output logic     rs_full,
    output logic     cdb_valid,
    output rob_tag_t cdb_tag,
    output word_t    cdb_value
);

    logic [RS_DEPTH-1:0] ent_valid;
    logic [RS_DEPTH-1:0] ent_rdy1;
    logic [RS_DEPTH-1:0] ent_rdy2;
    logic [RS_DEPTH-1:0] ent_older [RS_DEPTH];   // bit j set: entry j is older
    alu_op_e             ent_op    [RS_DEPTH];
    rob_tag_t            ent_tag   [RS_DEPTH];   // destination rob slot
    word_t               ent_val1  [RS_DEPTH];
    word_t               ent_val2  [RS_DEPTH];
    rob_tag_t            ent_tag1  [RS_DEPTH];   // producer tags while waiting
    rob_tag_t            ent_tag2  [RS_DEPTH];
    logic [RS_DEPTH-1:0] exec_ready;
    logic [RS_DEPTH-1:0] sel_oh;                 // one-hot, oldest ready
    logic [RS_DEPTH-1:0] free_oh;                // one-hot, lowest free slot
    logic                sel_any;
    alu_op_e             sel_op;
    rob_tag_t            sel_tag;
    word_t               sel_a;
    word_t               sel_b;
    logic                cdb_pending;

    function automatic word_t alu_calc(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];   // low 5 bits shift
            SLT:     return word_t'($signed(a) < $signed(b));
            SLTU:    return word_t'(a < b);
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return word_t'($signed(a) >>> b[4:0]);
            OR:      return a | b;
            AND:     return a & b;
            default: return a + b;
        endcase
    endfunction

    assign exec_ready = ent_valid & ent_rdy1 & ent_rdy2;
    assign rs_full    = &ent_valid;
    assign sel_any    = |sel_oh;
    assign cdb_valid  = cdb_pending & rdy_in;   // hidden during a pause

    always_comb
    begin
        free_oh = '0;
        sel_oh  = '0;
        sel_op  = ADD;
        sel_tag = '0;
        sel_a   = '0;
        sel_b   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--)   // lowest index ends up winning
        begin
            if (!ent_valid[i])
            begin
                free_oh = '0;
                free_oh[i] = 1'b1;
            end
        end
        for (int i = 0; i < RS_DEPTH; i++)
        begin
            sel_oh[i] = exec_ready[i] && !(|(exec_ready & ent_older[i]));   // none older ready
            if (sel_oh[i])
            begin
                sel_op  = ent_op[i];
                sel_tag = ent_tag[i];
                sel_a   = ent_val1[i];
                sel_b   = ent_val2[i];
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            ent_valid   <= '0;
            ent_rdy1    <= '0;
            ent_rdy2    <= '0;
            cdb_pending <= 1'b0;
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                ent_older[i] <= '0;
            end
        end
        else if (rdy_in)
        begin
            cdb_pending <= sel_any;
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                if (sel_oh[i])
                begin
                    ent_valid[i] <= 1'b0;   // leaves for the ALU
                end
                // snoop own bus for waiting operands
                if (ent_valid[i] && !ent_rdy1[i] && cdb_valid && (ent_tag1[i] == cdb_tag))
                begin
                    ent_rdy1[i] <= 1'b1;
                end
                if (ent_valid[i] && !ent_rdy2[i] && cdb_valid && (ent_tag2[i] == cdb_tag))
                begin
                    ent_rdy2[i] <= 1'b1;
                end
                if (alloc && free_oh[i])
                begin
                    ent_valid[i] <= 1'b1;
                    ent_rdy1[i]  <= src1_ready;
                    ent_rdy2[i]  <= src2_ready;
                    ent_older[i] <= ent_valid;   // everyone present is older
                end
                else if (alloc)
                begin
                    ent_older[i] <= ent_older[i] & ~free_oh;   // newcomer is younger
                end
            end
        end
    end

    // payload and bus data, no reset
    always_ff @(posedge clk_in)
    begin
        if (rdy_in)
        begin
            if (sel_any)
            begin
                cdb_tag   <= sel_tag;
                cdb_value <= alu_calc(sel_op, sel_a, sel_b);
            end
            for (int i = 0; i < RS_DEPTH; i++)
            begin
                if (alloc && free_oh[i])
                begin
                    ent_op[i]   <= alloc_op;
                    ent_tag[i]  <= alloc_tag;
                    ent_val1[i] <= src1_value;
                    ent_val2[i] <= src2_value;
                    ent_tag1[i] <= src1_tag;
                    ent_tag2[i] <= src2_tag;
                end
                else
                begin
                    if (cdb_valid && (ent_tag1[i] == cdb_tag) && !ent_rdy1[i])
                    begin
                        ent_val1[i] <= cdb_value;
                    end
                    if (cdb_valid && (ent_tag2[i] == cdb_tag) && !ent_rdy2[i])
                    begin
                        ent_val2[i] <= cdb_value;
                    end
                end
            end
        end
    end

endmodule

// ==== dispatch_unit.sv ====
// ################################################
// dispatch: back-pressure, accept strobe, operand resolution
// ################################################
`timescale 1ns/10ps

module dispatch_unit
    import tomasulo_pkg::*;
(
    input  logic     rdy_in,
    input  logic     issue_valid,
    input  logic     issue_use_imm,
    input  word_t    issue_imm,
    input  logic     rob_full,
    input  logic     rs_full,
    input  rob_tag_t rob_tail,
    input  logic     rf1_busy,
    input  logic     rf2_busy,
    input  word_t    rf1_value,
    input  word_t    rf2_value,
    input  rob_tag_t rf1_tag,
    input  rob_tag_t rf2_tag,
    input  logic     fwd1_ready,
    input  logic     fwd2_ready,
    input  word_t    fwd1_value,
    input  word_t    fwd2_value,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output logic     issue_ready,
    output logic     alloc,
    output rob_tag_t alloc_tag,
    output logic     src1_ready,
    output logic     src2_ready,
    output word_t    src1_value,
    output word_t    src2_value,
    output rob_tag_t src1_tag,
    output rob_tag_t src2_tag
);

    logic cdb_hit1;   // bus carries the producer this cycle
    logic cdb_hit2;

    assign issue_ready = !rob_full && !rs_full;
    assign alloc       = issue_valid && issue_ready && rdy_in;
    assign alloc_tag   = rob_tail;   // new op takes the rob tail

    assign cdb_hit1 = cdb_valid && (cdb_tag == rf1_tag);
    assign cdb_hit2 = cdb_valid && (cdb_tag == rf2_tag);

    // priority: register file, then rob entry, then the bus, else wait on tag
    assign src1_ready = !rf1_busy || fwd1_ready || cdb_hit1;
    assign src1_value = !rf1_busy  ? rf1_value  :
                        fwd1_ready ? fwd1_value : cdb_value;
    assign src1_tag   = rf1_tag;

    // immediate replaces rs2 entirely
    assign src2_ready = issue_use_imm || !rf2_busy || fwd2_ready || cdb_hit2;
    assign src2_value = issue_use_imm ? issue_imm  :
                        !rf2_busy     ? rf2_value  :
                        fwd2_ready    ? fwd2_value : cdb_value;
    assign src2_tag   = issue_use_imm ? '0 : rf2_tag;

endmodule

// ==== ooo_core.sv ====
// ################################################
// out-of-order core top: rename file, rob, station, dispatch
// ################################################
`timescale 1ns/10ps

module ooo_core
    import tomasulo_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     rdy_in,        // pause when low
    input  logic     issue_valid,
    input  logic     issue_use_imm,
    input  alu_op_e  issue_op,
    input  reg_idx_t issue_rs1,
    input  reg_idx_t issue_rs2,
    input  reg_idx_t issue_rd,
    input  word_t    issue_imm,
    output logic     issue_ready,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output word_t    commit_value
);

    logic     alloc;
    rob_tag_t alloc_tag;
    logic     rob_full;
    logic     rs_full;
    rob_tag_t rob_tail;
    logic     rf1_busy, rf2_busy;
    word_t    rf1_value, rf2_value;
    rob_tag_t rf1_tag, rf2_tag;
    logic     fwd1_ready, fwd2_ready;
    word_t    fwd1_value, fwd2_value;
    logic     src1_ready, src2_ready;
    word_t    src1_value, src2_value;
    rob_tag_t src1_tag, src2_tag;
    logic     cdb_valid;             // result broadcast
    rob_tag_t cdb_tag;
    word_t    cdb_value;
    rob_tag_t commit_tag;            // for the rename tag match

    dispatch_unit u_dispatch (
        .rdy_in, .issue_valid, .issue_use_imm, .issue_imm,
        .rob_full, .rs_full, .rob_tail,
        .rf1_busy, .rf2_busy, .rf1_value, .rf2_value, .rf1_tag, .rf2_tag,
        .fwd1_ready, .fwd2_ready, .fwd1_value, .fwd2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .issue_ready, .alloc, .alloc_tag,
        .src1_ready, .src2_ready, .src1_value, .src2_value, .src1_tag, .src2_tag
    );

    reg_rename_file u_regs (
        .clk_in, .rst_in, .rdy_in,
        .rs1(issue_rs1), .rs2(issue_rs2),
        .rf1_busy, .rf2_busy, .rf1_value, .rf2_value, .rf1_tag, .rf2_tag,
        .alloc, .alloc_rd(issue_rd), .alloc_tag,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    reorder_buffer u_rob (
        .clk_in, .rst_in, .rdy_in,
        .alloc, .alloc_rd(issue_rd), .rob_tail, .rob_full,
        .lookup1_tag(rf1_tag), .lookup2_tag(rf2_tag),   // follow the rename tags
        .fwd1_ready, .fwd2_ready, .fwd1_value, .fwd2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_rd, .commit_tag, .commit_value
    );

    reservation_station u_rs (
        .clk_in, .rst_in, .rdy_in,
        .alloc, .alloc_op(issue_op), .alloc_tag,
        .src1_ready, .src2_ready, .src1_value, .src2_value, .src1_tag, .src2_tag,
        .rs_full, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

// ==== tb_ooo_core.sv ====
// ##################################################
// random ALU stimulus for ooo_core with an
// in-order reference model and commit stream checker
// ##################################################
`timescale 1ns/10ps

module tb_ooo_core
    import tomasulo_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;   // cycles per wait loop

    logic     clk_in;
    logic     rst_in;
    logic     rdy_in;
    logic     issue_valid;
    logic     issue_use_imm;
    alu_op_e  issue_op;
    reg_idx_t issue_rs1;
    reg_idx_t issue_rs2;
    reg_idx_t issue_rd;
    word_t    issue_imm;
    logic     issue_ready;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_value;

    word_t    model_regs [NUM_REGS];   // in-order architectural state
    reg_idx_t exp_rd_q [$];            // expected commits in acceptance order
    word_t    exp_val_q [$];
    string    phase;                   // current test name
    int       errors;
    int       timeouts;
    int       n_accept;
    int       n_commit;
    logic     saw_not_ready;           // back-pressure observed
    logic     pause_mode;              // random rdy_in when set

    ooo_core dut (
        .clk_in, .rst_in, .rdy_in,
        .issue_valid, .issue_use_imm, .issue_op,
        .issue_rs1, .issue_rs2, .issue_rd, .issue_imm,
        .issue_ready, .commit_valid, .commit_rd, .commit_value
    );

    always #10 clk_in = ~clk_in;   // 20 ns period

    // RV32I ALU semantics
    function automatic word_t reference_alu(input alu_op_e op, input word_t a, input word_t b);
        logic [63:0] ext;
        logic [4:0]  sh;
        sh  = b[4:0];
        ext = {{32{a[31]}}, a} >> sh;   // sign-filled upper half
        case (op)
            ADD:     reference_alu = a + b;
            SUB:     reference_alu = a + ~b + 32'd1;
            SLL:     reference_alu = a << sh;
            SLT:     reference_alu = {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            SLTU:    reference_alu = {31'b0, a < b};
            XOR:     reference_alu = a ^ b;
            SRL:     reference_alu = a >> sh;
            SRA:     reference_alu = ext[31:0];
            OR:      reference_alu = a | b;
            AND:     reference_alu = a & b;
            default: reference_alu = 'x;
        endcase
    endfunction

    function automatic alu_op_e random_op();
        return alu_op_e'(4'($urandom_range(9)));   // all ten ops
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            errors++;
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    // drive at negedge, hold until accepted at a rising edge
    task automatic send_op(input alu_op_e op, input reg_idx_t rs1, input reg_idx_t rs2,
                           input reg_idx_t rd, input word_t imm, input logic use_imm);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        if (timeouts != 0)
        begin
            return;   // run already broken
        end
        @(negedge clk_in);
        issue_valid   = 1'b1;
        issue_op      = op;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_rd      = rd;
        issue_imm     = imm;
        issue_use_imm = use_imm;
        do
        begin
            @(posedge clk_in);
            accepted = issue_ready && rdy_in;   // pre-edge values
            waited++;
        end
        while (!accepted && (waited < WAIT_LIMIT));
        if (!accepted)
        begin
            timeouts++;
            $display("Timeout: operation in %s was never accepted", phase);
        end
    endtask

    task automatic stop_issue(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk_in);
            issue_valid = 1'b0;
        end
    endtask

    // wait for every accepted op to commit
    task automatic drain_commits();
        int waited;
        waited = 0;
        @(negedge clk_in);
        issue_valid = 1'b0;
        while ((exp_rd_q.size() != 0) && (waited < WAIT_LIMIT) && (timeouts == 0))
        begin
            @(negedge clk_in);
            waited++;
        end
        if (exp_rd_q.size() != 0)
        begin
            timeouts++;
            $display("Timeout: %0d operations in %s never committed", exp_rd_q.size(), phase);
        end
    endtask

    always @(negedge clk_in)
    begin
        if (pause_mode)
            rdy_in = ($urandom_range(3) != 0);   // low about a quarter of cycles
        else
            rdy_in = 1'b1;
    end

    // reference model and commit checker on pre-edge values
    always @(posedge clk_in)
    begin : monitor
        word_t operand2;
        word_t result;
        if (!rst_in)
        begin
            if (!issue_ready)
                saw_not_ready = 1'b1;
            if (!rdy_in)
                check_value({phase, "/paused_commit"}, 0, commit_valid);
            if (commit_valid)
            begin
                n_commit++;
                if (exp_rd_q.size() == 0)
                begin
                    errors++;
                    $display("Commit arrived in %s with nothing outstanding", phase);
                end
                else
                begin
                    check_value({phase, "/commit_rd"}, exp_rd_q.pop_front(), commit_rd);
                    check_value({phase, "/commit_value"}, exp_val_q.pop_front(), commit_value);
                end
            end
            if (issue_valid && issue_ready && rdy_in)
            begin
                operand2 = issue_use_imm ? issue_imm : model_regs[issue_rs2];
                result   = reference_alu(issue_op, model_regs[issue_rs1], operand2);
                exp_rd_q.push_back(issue_rd);
                exp_val_q.push_back(result);
                if (issue_rd != '0)
                    model_regs[issue_rd] = result;   // x0 stays zero
                n_accept++;
            end
        end
    end

    initial
    begin
        void'($urandom(64284));
        clk_in        = 1'b0;
        rst_in        = 1'b1;
        rdy_in        = 1'b1;
        issue_valid   = 1'b0;
        issue_use_imm = 1'b0;
        issue_op      = ADD;
        issue_rs1     = '0;
        issue_rs2     = '0;
        issue_rd      = '0;
        issue_imm     = '0;
        errors        = 0;
        timeouts      = 0;
        n_accept      = 0;
        n_commit      = 0;
        saw_not_ready = 1'b0;
        pause_mode    = 1'b0;
        phase         = "reset";
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;
        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;
        repeat (2)
        begin
            @(negedge clk_in);
            check_value("reset/commit_valid", 0, commit_valid);
            check_value("reset/issue_ready", 1, issue_ready);
        end

        // rd = x0 keeps every source at its reset value
        phase = "reset_reads";
        for (int i = 0; i < 12; i++)
            send_op(random_op(), reg_idx_t'($urandom_range(31)), reg_idx_t'($urandom_range(31)),
                    '0, '0, 1'b0);
        drain_commits();

        phase = "independent";
        for (int i = 0; i < 80; i++)
        begin
            send_op(random_op(), reg_idx_t'($urandom_range(31)), reg_idx_t'($urandom_range(31)),
                    reg_idx_t'($urandom_range(1, 31)), $urandom, 1'($urandom_range(1)));
            if ($urandom_range(3) == 0)
                stop_issue($urandom_range(1, 3));   // occasional bubble
        end
        drain_commits();

        phase = "chains";   // few registers so sources are recent results
        for (int i = 0; i < 60; i++)
            send_op(random_op(), reg_idx_t'($urandom_range(1, 4)), reg_idx_t'($urandom_range(1, 4)),
                    reg_idx_t'($urandom_range(1, 4)), $urandom, 1'($urandom_range(3) == 0));
        drain_commits();

        phase         = "bursts";
        saw_not_ready = 1'b0;
        for (int b = 0; b < 3; b++)
        begin
            for (int i = 0; i < 16; i++)   // each op waits on the one before
                send_op(i[0] ? XOR : ADD, reg_idx_t'(b + 5), reg_idx_t'(b + 5),
                        reg_idx_t'(b + 5), $urandom, 1'b1);
            drain_commits();
        end
        check_value("bursts/issue_ready_fell", 1, saw_not_ready);

        phase      = "pause";
        pause_mode = 1'b1;
        for (int i = 0; i < 60; i++)
            send_op(random_op(), reg_idx_t'($urandom_range(1, 6)), reg_idx_t'($urandom_range(1, 6)),
                    reg_idx_t'($urandom_range(1, 6)), $urandom, 1'($urandom_range(1)));
        drain_commits();
        pause_mode = 1'b0;

        phase = "x0_writes";
        for (int i = 0; i < 30; i++)
            send_op(random_op(), reg_idx_t'($urandom_range(3)), reg_idx_t'($urandom_range(3)),
                    reg_idx_t'(i[0] ? 0 : $urandom_range(1, 3)), $urandom, 1'(i % 3 == 0));
        drain_commits();

        stop_issue(8);   // room for stray commits
        check_value("final/commit_count", n_accept, n_commit);
        check_value("final/outstanding", 0, exp_rd_q.size());
        $display("errors=%0d timeouts=%0d accepted=%0d committed=%0d",
                 errors, timeouts, n_accept, n_commit);
        if ((errors == 0) && (timeouts == 0))
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
tomasulo_pkg.sv
reg_rename_file.sv
reorder_buffer.sv
reservation_station.sv
dispatch_unit.sv
ooo_core.sv
tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - tomasulo_pkg.sv
  - reg_rename_file.sv
  - reorder_buffer.sv
  - reservation_station.sv
  - dispatch_unit.sv
  - ooo_core.sv
  - target: test
    files:
      - tb_ooo_core.sv
